/* exec_pkg.sv */
`default_nettype none

package exec_pkg;

  // Datapath widths
  parameter int WORD_W     = 32;
  parameter int REG_ADDR_W = 5;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Branch function codes follow funct3 of the branch opcode
  // bit 2 picks less-than over equality, bit 1 unsigned, bit 0 inverts
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_func_t;

  typedef struct packed {
    word_t hi;
    word_t lo;
  } word_pair_t;

  // Full multiplier result read whole or as two words
  typedef union packed {
    logic [2*WORD_W-1:0] dword;
    word_pair_t          words;
  } mul_product_u;

endpackage

`default_nettype wire

/* branch_resolve.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_resolve (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   alu_ena,
  input  logic                   branch_instr,
  input  logic                   jump_instr,
  input  exec_pkg::branch_func_t branch_func,
  input  logic                   prediction,
  input  exec_pkg::word_t        pc,
  input  exec_pkg::word_t        port_a,
  input  exec_pkg::word_t        port_b,
  input  exec_pkg::word_t        immediate,
  output logic                   taken,
  output logic                   mispredict,
  output logic                   mispredict_ff,
  output exec_pkg::word_t        redirect_addr,
  output exec_pkg::word_t        link_data,
  output logic                   branch_done
);

  logic            cond;
  logic            equal;
  logic            signed_lt;
  logic            unsigned_lt;
  logic            branch_miss;
  exec_pkg::word_t pc4;
  exec_pkg::word_t branch_target;
  exec_pkg::word_t jump_sum;

  // Comparator outputs
  assign equal       = (port_a == port_b);
  assign signed_lt   = ($signed(port_a) < $signed(port_b));
  assign unsigned_lt = (port_a < port_b);

  always_comb begin
    case (branch_func)
      exec_pkg::BEQ:  cond = equal;
      exec_pkg::BNE:  cond = ~equal;
      exec_pkg::BLT:  cond = signed_lt;
      exec_pkg::BGE:  cond = ~signed_lt;
      exec_pkg::BLTU: cond = unsigned_lt;
      exec_pkg::BGEU: cond = ~unsigned_lt;
      default:        cond = 1'b0;
    endcase
  end

  assign taken = branch_instr & cond;

  // Targets
  assign pc4           = pc + exec_pkg::word_t'(4);
  assign branch_target = pc + immediate;
  assign jump_sum      = port_a + immediate;

  // Prediction disagreed with the resolved outcome
  assign branch_miss = branch_instr & (prediction ^ taken);
  assign mispredict  = alu_ena & (jump_instr | branch_miss);

  always_comb begin
    if (jump_instr) begin
      redirect_addr = {jump_sum[exec_pkg::WORD_W-1:1], 1'b0};
    end else if (branch_miss && taken) begin
      redirect_addr = branch_target;
    end else begin
      redirect_addr = pc4;
    end
  end

  assign link_data   = pc4;
  assign branch_done = alu_ena;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mispredict_ff <= 1'b0;
    end else begin
      mispredict_ff <= mispredict;
    end
  end

endmodule

`default_nettype wire

/* mul_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_pipeline #(
  parameter int CB_ENTRIES = 16,
  parameter int MUL_STAGES = 3
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          mul_ena,
  input  logic                          mul_high,
  input  logic                          mul_signed,
  input  exec_pkg::word_t               mul_a,
  input  exec_pkg::word_t               mul_b,
  input  exec_pkg::reg_addr_t           reg_rd_mu,
  input  logic [$clog2(CB_ENTRIES)-1:0] index_mu,
  output logic                          mul_done,
  output exec_pkg::reg_addr_t           mul_rd,
  output logic [$clog2(CB_ENTRIES)-1:0] mul_index,
  output exec_pkg::word_t               mul_wdata
);

  localparam int IDX_W = $clog2(CB_ENTRIES);
  localparam int LAST  = MUL_STAGES - 1;

  // One extra bit carries the sign for both signed and unsigned operands
  logic signed [exec_pkg::WORD_W:0]     op_a;
  logic signed [exec_pkg::WORD_W:0]     op_b;
  logic signed [2*exec_pkg::WORD_W+1:0] full_prod;
  exec_pkg::mul_product_u               prod_in;

  logic [MUL_STAGES-1:0]  valid_q;
  logic [MUL_STAGES-1:0]  high_q;
  exec_pkg::mul_product_u prod_q [MUL_STAGES];
  exec_pkg::reg_addr_t    rd_q   [MUL_STAGES];
  logic [IDX_W-1:0]       idx_q  [MUL_STAGES];

  assign op_a          = {mul_signed & mul_a[exec_pkg::WORD_W-1], mul_a};
  assign op_b          = {mul_signed & mul_b[exec_pkg::WORD_W-1], mul_b};
  assign full_prod     = op_a * op_b;
  assign prod_in.dword = full_prod[2*exec_pkg::WORD_W-1:0];

  // Valid chain
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= mul_ena;
      for (int i = 1; i < MUL_STAGES; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // Product, word select, destination and index move alongside
  always_ff @(posedge CLK) begin
    prod_q[0] <= prod_in;
    high_q[0] <= mul_high;
    rd_q[0]   <= reg_rd_mu;
    idx_q[0]  <= index_mu;
    for (int i = 1; i < MUL_STAGES; i++) begin
      prod_q[i] <= prod_q[i-1];
      high_q[i] <= high_q[i-1];
      rd_q[i]   <= rd_q[i-1];
      idx_q[i]  <= idx_q[i-1];
    end
  end

  assign mul_done  = valid_q[LAST];
  assign mul_rd    = rd_q[LAST];
  assign mul_index = idx_q[LAST];
  assign mul_wdata = high_q[LAST] ? prod_q[LAST].words.hi : prod_q[LAST].words.lo;

endmodule

`default_nettype wire

/* completion_latch.sv */
`timescale 1ns/10ps
`default_nettype none

module completion_latch #(
  parameter int CB_ENTRIES = 16
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          flush,
  input  logic                          branch_done,
  input  logic                          jump_instr,
  input  exec_pkg::word_t               link_data,
  input  exec_pkg::reg_addr_t           reg_rd_a,
  input  logic [$clog2(CB_ENTRIES)-1:0] index_a,
  input  logic                          mul_done,
  input  exec_pkg::reg_addr_t           mul_rd,
  input  logic [$clog2(CB_ENTRIES)-1:0] mul_index,
  input  exec_pkg::word_t               mul_wdata,
  output logic                          bypass_valid_alu,
  output exec_pkg::reg_addr_t           bypass_rd_alu,
  output exec_pkg::word_t               bypass_data_alu,
  output logic                          bypass_valid_mul,
  output exec_pkg::reg_addr_t           bypass_rd_mul,
  output exec_pkg::word_t               bypass_data_mul,
  output logic                          cb_ready_a,
  output logic                          cb_wen_a,
  output logic [$clog2(CB_ENTRIES)-1:0] cb_index_a,
  output exec_pkg::reg_addr_t           cb_vd_a,
  output exec_pkg::word_t               cb_wdata_a,
  output logic                          cb_ready_mu,
  output logic [$clog2(CB_ENTRIES)-1:0] cb_index_mu,
  output exec_pkg::reg_addr_t           cb_vd_mu,
  output exec_pkg::word_t               cb_wdata_mu
);

  logic ready_a;
  logic wen_a;

  // Lane a only writes back for jumps
  assign ready_a = branch_done;
  assign wen_a   = ready_a & jump_instr;

  // Bypass in the same cycle as the lane result
  assign bypass_valid_alu = wen_a;
  assign bypass_rd_alu    = reg_rd_a;
  assign bypass_data_alu  = link_data;
  assign bypass_valid_mul = mul_done;
  assign bypass_rd_mul    = mul_rd;
  assign bypass_data_mul  = mul_wdata;

  // Execute to commit latch
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cb_ready_a  <= 1'b0;
      cb_wen_a    <= 1'b0;
      cb_index_a  <= '0;
      cb_vd_a     <= '0;
      cb_wdata_a  <= '0;
      cb_ready_mu <= 1'b0;
      cb_index_mu <= '0;
      cb_vd_mu    <= '0;
      cb_wdata_mu <= '0;
    end else if (flush) begin
      // Squash whatever finished this cycle
      cb_ready_a  <= 1'b0;
      cb_wen_a    <= 1'b0;
      cb_index_a  <= '0;
      cb_vd_a     <= '0;
      cb_wdata_a  <= '0;
      cb_ready_mu <= 1'b0;
      cb_index_mu <= '0;
      cb_vd_mu    <= '0;
      cb_wdata_mu <= '0;
    end else begin
      cb_ready_a  <= ready_a;
      cb_wen_a    <= wen_a;
      cb_index_a  <= index_a;
      cb_vd_a     <= reg_rd_a;
      cb_wdata_a  <= link_data;
      cb_ready_mu <= mul_done;
      cb_index_mu <= mul_index;
      cb_vd_mu    <= mul_rd;
      cb_wdata_mu <= mul_wdata;
    end
  end

endmodule

`default_nettype wire

/* ooo_execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module ooo_execute_stage #(
  parameter int CB_ENTRIES = 16,
  parameter int MUL_STAGES = 3
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          flush,
  // Lane a carries branches and jumps
  input  logic                          alu_ena,
  input  logic                          branch_instr,
  input  logic                          jump_instr,
  input  exec_pkg::branch_func_t        branch_func,
  input  logic                          prediction,
  input  exec_pkg::word_t               pc,
  input  exec_pkg::word_t               port_a,
  input  exec_pkg::word_t               port_b,
  input  exec_pkg::word_t               immediate,
  input  exec_pkg::reg_addr_t           reg_rd_a,
  input  logic [$clog2(CB_ENTRIES)-1:0] index_a,
  // Multiply lane
  input  logic                          mul_ena,
  input  logic                          mul_high,
  input  logic                          mul_signed,
  input  exec_pkg::word_t               mul_a,
  input  exec_pkg::word_t               mul_b,
  input  exec_pkg::reg_addr_t           reg_rd_mu,
  input  logic [$clog2(CB_ENTRIES)-1:0] index_mu,
  // Front end redirect
  output logic                          taken,
  output logic                          mispredict,
  output exec_pkg::word_t               redirect_addr,
  output logic                          mispredict_ff,
  // Bypass network
  output logic                          bypass_valid_alu,
  output exec_pkg::reg_addr_t           bypass_rd_alu,
  output exec_pkg::word_t               bypass_data_alu,
  output logic                          bypass_valid_mul,
  output exec_pkg::reg_addr_t           bypass_rd_mul,
  output exec_pkg::word_t               bypass_data_mul,
  // Completion buffer writes
  output logic                          cb_ready_a,
  output logic                          cb_wen_a,
  output logic [$clog2(CB_ENTRIES)-1:0] cb_index_a,
  output exec_pkg::reg_addr_t           cb_vd_a,
  output exec_pkg::word_t               cb_wdata_a,
  output logic                          cb_ready_mu,
  output logic [$clog2(CB_ENTRIES)-1:0] cb_index_mu,
  output exec_pkg::reg_addr_t           cb_vd_mu,
  output exec_pkg::word_t               cb_wdata_mu
);

  exec_pkg::word_t               link_data;
  logic                          branch_done;
  logic                          mul_done;
  exec_pkg::reg_addr_t           mul_rd;
  logic [$clog2(CB_ENTRIES)-1:0] mul_index;
  exec_pkg::word_t               mul_wdata;

  branch_resolve u_branch_resolve (
    .CLK           (CLK),
    .nRST          (nRST),
    .alu_ena       (alu_ena),
    .branch_instr  (branch_instr),
    .jump_instr    (jump_instr),
    .branch_func   (branch_func),
    .prediction    (prediction),
    .pc            (pc),
    .port_a        (port_a),
    .port_b        (port_b),
    .immediate     (immediate),
    .taken         (taken),
    .mispredict    (mispredict),
    .mispredict_ff (mispredict_ff),
    .redirect_addr (redirect_addr),
    .link_data     (link_data),
    .branch_done   (branch_done)
  );

  mul_pipeline #(
    .CB_ENTRIES (CB_ENTRIES),
    .MUL_STAGES (MUL_STAGES)
  ) u_mul_pipeline (
    .CLK        (CLK),
    .nRST       (nRST),
    .mul_ena    (mul_ena),
    .mul_high   (mul_high),
    .mul_signed (mul_signed),
    .mul_a      (mul_a),
    .mul_b      (mul_b),
    .reg_rd_mu  (reg_rd_mu),
    .index_mu   (index_mu),
    .mul_done   (mul_done),
    .mul_rd     (mul_rd),
    .mul_index  (mul_index),
    .mul_wdata  (mul_wdata)
  );

  completion_latch #(
    .CB_ENTRIES (CB_ENTRIES)
  ) u_completion_latch (
    .CLK              (CLK),
    .nRST             (nRST),
    .flush            (flush),
    .branch_done      (branch_done),
    .jump_instr       (jump_instr),
    .link_data        (link_data),
    .reg_rd_a         (reg_rd_a),
    .index_a          (index_a),
    .mul_done         (mul_done),
    .mul_rd           (mul_rd),
    .mul_index        (mul_index),
    .mul_wdata        (mul_wdata),
    .bypass_valid_alu (bypass_valid_alu),
    .bypass_rd_alu    (bypass_rd_alu),
    .bypass_data_alu  (bypass_data_alu),
    .bypass_valid_mul (bypass_valid_mul),
    .bypass_rd_mul    (bypass_rd_mul),
    .bypass_data_mul  (bypass_data_mul),
    .cb_ready_a       (cb_ready_a),
    .cb_wen_a         (cb_wen_a),
    .cb_index_a       (cb_index_a),
    .cb_vd_a          (cb_vd_a),
    .cb_wdata_a       (cb_wdata_a),
    .cb_ready_mu      (cb_ready_mu),
    .cb_index_mu      (cb_index_mu),
    .cb_vd_mu         (cb_vd_mu),
    .cb_wdata_mu      (cb_wdata_mu)
  );

endmodule

`default_nettype wire

/* exec_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_properties (
  input logic CLK,
  input logic nRST,
  input logic flush,
  input logic cb_ready_a,
  input logic cb_wen_a,
  input logic cb_ready_mu,
  input logic bypass_valid_alu,
  input logic bypass_valid_mul
);

  int fail_count = 0;

  // Nothing completes while reset is held
  reset_quiet: assert property (@(posedge CLK)
    !nRST |-> !cb_ready_a && !cb_wen_a && !cb_ready_mu && !bypass_valid_alu && !bypass_valid_mul)
  else begin
    $error("completion or bypass valid high during reset");
    fail_count++;
  end

  // First capture out of reset stays empty
  after_reset: assert property (@(posedge CLK)
    $rose(nRST) |=> !cb_ready_a && !cb_wen_a && !cb_ready_mu)
  else begin
    $error("completion output high right after reset");
    fail_count++;
  end

  flush_clears: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !cb_ready_a && !cb_wen_a && !cb_ready_mu)
  else begin
    $error("completion output survived a flush");
    fail_count++;
  end

  // A jump on the bypass is written to the completion buffer next cycle
  jump_reaches_cb: assert property (@(posedge CLK) disable iff (!nRST)
    bypass_valid_alu && !flush |=> cb_ready_a && cb_wen_a)
  else begin
    $error("jump result missing from the completion latch");
    fail_count++;
  end

endmodule

bind completion_latch exec_properties u_props (
  .CLK              (CLK),
  .nRST             (nRST),
  .flush            (flush),
  .cb_ready_a       (cb_ready_a),
  .cb_wen_a         (cb_wen_a),
  .cb_ready_mu      (cb_ready_mu),
  .bypass_valid_alu (bypass_valid_alu),
  .bypass_valid_mul (bypass_valid_mul)
);

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_checker #(
  parameter int CB_ENTRIES = 16,
  parameter int MUL_STAGES = 3
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          flush,
  input  logic                          alu_ena,
  input  logic                          branch_instr,
  input  logic                          jump_instr,
  input  exec_pkg::branch_func_t        branch_func,
  input  logic                          prediction,
  input  exec_pkg::word_t               pc,
  input  exec_pkg::word_t               port_a,
  input  exec_pkg::word_t               port_b,
  input  exec_pkg::word_t               immediate,
  input  exec_pkg::reg_addr_t           reg_rd_a,
  input  logic [$clog2(CB_ENTRIES)-1:0] index_a,
  input  logic                          mul_ena,
  input  logic                          mul_high,
  input  logic                          mul_signed,
  input  exec_pkg::word_t               mul_a,
  input  exec_pkg::word_t               mul_b,
  input  exec_pkg::reg_addr_t           reg_rd_mu,
  input  logic [$clog2(CB_ENTRIES)-1:0] index_mu,
  input  logic                          taken,
  input  logic                          mispredict,
  input  exec_pkg::word_t               redirect_addr,
  input  logic                          mispredict_ff,
  input  logic                          bypass_valid_alu,
  input  exec_pkg::reg_addr_t           bypass_rd_alu,
  input  exec_pkg::word_t               bypass_data_alu,
  input  logic                          bypass_valid_mul,
  input  exec_pkg::reg_addr_t           bypass_rd_mul,
  input  exec_pkg::word_t               bypass_data_mul,
  input  logic                          cb_ready_a,
  input  logic                          cb_wen_a,
  input  logic [$clog2(CB_ENTRIES)-1:0] cb_index_a,
  input  exec_pkg::reg_addr_t           cb_vd_a,
  input  exec_pkg::word_t               cb_wdata_a,
  input  logic                          cb_ready_mu,
  input  logic [$clog2(CB_ENTRIES)-1:0] cb_index_mu,
  input  exec_pkg::reg_addr_t           cb_vd_mu,
  input  exec_pkg::word_t               cb_wdata_mu,
  output int                            check_count,
  output int                            error_count
);

  localparam int IDX_W = $clog2(CB_ENTRIES);

  int unsigned cycle;

  // Multiplies in flight with the oldest first
  int unsigned         mul_due_q  [$];
  exec_pkg::word_t     mul_data_q [$];
  exec_pkg::reg_addr_t mul_rd_q   [$];
  logic [IDX_W-1:0]    mul_idx_q  [$];

  // Lane results seen in the previous cycle
  logic                prev_clear;
  logic                prev_misp;
  logic                prev_ready_a;
  logic                prev_wen_a;
  logic [IDX_W-1:0]    prev_idx_a;
  exec_pkg::reg_addr_t prev_vd_a;
  exec_pkg::word_t     prev_wdata_a;
  logic                prev_ready_mu;
  logic [IDX_W-1:0]    prev_idx_mu;
  exec_pkg::reg_addr_t prev_vd_mu;
  exec_pkg::word_t     prev_wdata_mu;

  initial begin
    check_count = 0;
    error_count = 0;
  end

  // Expected {taken, mispredict, redirect} of a branch or jump
  function automatic logic [exec_pkg::WORD_W+1:0] resolve_ref(
    input logic                   jump,
    input exec_pkg::branch_func_t func,
    input logic                   pred,
    input exec_pkg::word_t        pc_v,
    input exec_pkg::word_t        a,
    input exec_pkg::word_t        b,
    input exec_pkg::word_t        imm
  );
    logic            tk;
    logic            miss;
    exec_pkg::word_t target;
    case (func)
      exec_pkg::BEQ:  tk = (a == b);
      exec_pkg::BNE:  tk = (a != b);
      exec_pkg::BLT:  tk = ($signed(a) < $signed(b));
      exec_pkg::BGE:  tk = ($signed(a) >= $signed(b));
      exec_pkg::BLTU: tk = (a < b);
      default:        tk = (a >= b);
    endcase
    if (jump) begin
      miss   = 1'b1;
      target = (a + imm) & ~32'd1;
    end else begin
      miss   = pred ^ tk;
      target = (miss && tk) ? pc_v + imm : pc_v + 32'd4;
    end
    return {tk, miss, target};
  endfunction

  // Hi or lo word of the full 64-bit product
  function automatic exec_pkg::word_t product_ref(
    input logic            sgn,
    input logic            high,
    input exec_pkg::word_t a,
    input exec_pkg::word_t b
  );
    longint                 sa;
    longint                 sb;
    exec_pkg::mul_product_u prod;
    if (sgn) begin
      sa = longint'($signed(a));
      sb = longint'($signed(b));
    end else begin
      sa = longint'({32'd0, a});
      sb = longint'({32'd0, b});
    end
    prod.dword = sa * sb;
    return high ? prod.words.hi : prod.words.lo;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, exp, got);
    end
  endtask

  // Compare mid-cycle while inputs and outputs are stable
  always @(negedge CLK) begin : compare
    logic [exec_pkg::WORD_W+1:0] ref_a;
    logic                        mul_now;
    if (!nRST) begin
      check_value("mispredict_ff", 32'(mispredict_ff), 32'd0);
      check_value("cb_ready_a", 32'(cb_ready_a), 32'd0);
      check_value("cb_wen_a", 32'(cb_wen_a), 32'd0);
      check_value("cb_ready_mu", 32'(cb_ready_mu), 32'd0);
      check_value("bypass_valid_mul", 32'(bypass_valid_mul), 32'd0);
      prev_clear = 1'b1;
      prev_misp  = 1'b0;
      cycle      = 0;
      mul_due_q.delete();
      mul_data_q.delete();
      mul_rd_q.delete();
      mul_idx_q.delete();
    end else begin
      cycle++;

      // Lane a in its issue cycle
      ref_a = resolve_ref(jump_instr, branch_func, prediction, pc, port_a, port_b, immediate);
      if (alu_ena) begin
        if (branch_instr) begin
          check_value("taken", 32'(taken), 32'(ref_a[exec_pkg::WORD_W+1]));
        end
        check_value("redirect_addr", redirect_addr, ref_a[exec_pkg::WORD_W-1:0]);
      end
      check_value("mispredict", 32'(mispredict), 32'(alu_ena & ref_a[exec_pkg::WORD_W]));
      check_value("mispredict_ff", 32'(mispredict_ff), 32'(prev_misp));
      check_value("bypass_valid_alu", 32'(bypass_valid_alu), 32'(alu_ena & jump_instr));
      if (alu_ena && jump_instr) begin
        check_value("bypass_rd_alu", 32'(bypass_rd_alu), 32'(reg_rd_a));
        check_value("bypass_data_alu", bypass_data_alu, pc + 32'd4);
      end

      // Multiply lane
      if (mul_ena) begin
        mul_due_q.push_back(cycle + MUL_STAGES);
        mul_data_q.push_back(product_ref(mul_signed, mul_high, mul_a, mul_b));
        mul_rd_q.push_back(reg_rd_mu);
        mul_idx_q.push_back(index_mu);
      end
      mul_now = (mul_due_q.size() > 0) && (mul_due_q[0] == cycle);
      check_value("bypass_valid_mul", 32'(bypass_valid_mul), 32'(mul_now));
      if (mul_now) begin
        check_value("bypass_rd_mul", 32'(bypass_rd_mul), 32'(mul_rd_q[0]));
        check_value("bypass_data_mul", bypass_data_mul, mul_data_q[0]);
        check_value("mul_index", 32'(uut_index()), 32'(mul_idx_q[0]));
      end

      // Completion latch holds the previous cycle
      if (prev_clear) begin
        check_value("cb_ready_a", 32'(cb_ready_a), 32'd0);
        check_value("cb_wen_a", 32'(cb_wen_a), 32'd0);
        check_value("cb_index_a", 32'(cb_index_a), 32'd0);
        check_value("cb_vd_a", 32'(cb_vd_a), 32'd0);
        check_value("cb_wdata_a", cb_wdata_a, 32'd0);
        check_value("cb_ready_mu", 32'(cb_ready_mu), 32'd0);
        check_value("cb_index_mu", 32'(cb_index_mu), 32'd0);
        check_value("cb_vd_mu", 32'(cb_vd_mu), 32'd0);
        check_value("cb_wdata_mu", cb_wdata_mu, 32'd0);
      end else begin
        check_value("cb_ready_a", 32'(cb_ready_a), 32'(prev_ready_a));
        check_value("cb_wen_a", 32'(cb_wen_a), 32'(prev_wen_a));
        check_value("cb_index_a", 32'(cb_index_a), 32'(prev_idx_a));
        check_value("cb_vd_a", 32'(cb_vd_a), 32'(prev_vd_a));
        check_value("cb_wdata_a", cb_wdata_a, prev_wdata_a);
        check_value("cb_ready_mu", 32'(cb_ready_mu), 32'(prev_ready_mu));
        if (prev_ready_mu) begin
          check_value("cb_index_mu", 32'(cb_index_mu), 32'(prev_idx_mu));
          check_value("cb_vd_mu", 32'(cb_vd_mu), 32'(prev_vd_mu));
          check_value("cb_wdata_mu", cb_wdata_mu, prev_wdata_mu);
        end
      end

      prev_clear    = flush;
      prev_misp     = alu_ena & ref_a[exec_pkg::WORD_W];
      prev_ready_a  = alu_ena;
      prev_wen_a    = alu_ena & jump_instr;
      prev_idx_a    = index_a;
      prev_vd_a     = reg_rd_a;
      prev_wdata_a  = pc + 32'd4;
      prev_ready_mu = mul_now;
      if (mul_now) begin
        mul_due_q.delete(0);
        prev_wdata_mu = mul_data_q.pop_front();
        prev_vd_mu    = mul_rd_q.pop_front();
        prev_idx_mu   = mul_idx_q.pop_front();
      end
    end
  end

  // Multiply index leaves the top level only through the completion latch
  function automatic logic [IDX_W-1:0] uut_index();
    return tb_ooo_execute_stage.uut.mul_index;
  endfunction

endmodule

`default_nettype wire

/* tb_ooo_execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ooo_execute_stage;

  localparam int CB_ENTRIES     = 16;
  localparam int MUL_STAGES     = 3;
  localparam int IDX_W          = $clog2(CB_ENTRIES);
  localparam int RESET_CYCLES   = 5;
  localparam int DIRECTED       = 32;
  localparam int RANDOM_CYCLES  = 400;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + DIRECTED + RANDOM_CYCLES + MUL_STAGES + 50;
  localparam logic [31:0] SEED  = 32'hd7421217;

  logic                   CLK;
  logic                   nRST;
  logic                   flush;
  logic                   alu_ena;
  logic                   branch_instr;
  logic                   jump_instr;
  exec_pkg::branch_func_t branch_func;
  logic                   prediction;
  exec_pkg::word_t        pc;
  exec_pkg::word_t        port_a;
  exec_pkg::word_t        port_b;
  exec_pkg::word_t        immediate;
  exec_pkg::reg_addr_t    reg_rd_a;
  logic [IDX_W-1:0]       index_a;
  logic                   mul_ena;
  logic                   mul_high;
  logic                   mul_signed;
  exec_pkg::word_t        mul_a;
  exec_pkg::word_t        mul_b;
  exec_pkg::reg_addr_t    reg_rd_mu;
  logic [IDX_W-1:0]       index_mu;

  logic                   taken;
  logic                   mispredict;
  exec_pkg::word_t        redirect_addr;
  logic                   mispredict_ff;
  logic                   bypass_valid_alu;
  exec_pkg::reg_addr_t    bypass_rd_alu;
  exec_pkg::word_t        bypass_data_alu;
  logic                   bypass_valid_mul;
  exec_pkg::reg_addr_t    bypass_rd_mul;
  exec_pkg::word_t        bypass_data_mul;
  logic                   cb_ready_a;
  logic                   cb_wen_a;
  logic [IDX_W-1:0]       cb_index_a;
  exec_pkg::reg_addr_t    cb_vd_a;
  exec_pkg::word_t        cb_wdata_a;
  logic                   cb_ready_mu;
  logic [IDX_W-1:0]       cb_index_mu;
  exec_pkg::reg_addr_t    cb_vd_mu;
  exec_pkg::word_t        cb_wdata_mu;

  int check_count;
  int error_count;
  int assert_fails;
  int cycle_count;

  exec_pkg::branch_func_t funcs [6] = '{
    exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT,
    exec_pkg::BGE, exec_pkg::BLTU, exec_pkg::BGEU
  };
  // Signed overflow corners
  exec_pkg::word_t corners [4] = '{
    32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0001
  };

  ooo_execute_stage #(
    .CB_ENTRIES (CB_ENTRIES),
    .MUL_STAGES (MUL_STAGES)
  ) uut (.*);

  tb_checker #(
    .CB_ENTRIES (CB_ENTRIES),
    .MUL_STAGES (MUL_STAGES)
  ) u_check (.*);

  initial begin
    CLK = 1'b0;
    forever begin
      #10 CLK = ~CLK;
    end
  end

  task automatic next_cycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic drive_idle();
    flush        = 1'b0;
    alu_ena      = 1'b0;
    branch_instr = 1'b0;
    jump_instr   = 1'b0;
    branch_func  = exec_pkg::BEQ;
    prediction   = 1'b0;
    pc           = '0;
    port_a       = '0;
    port_b       = '0;
    immediate    = '0;
    reg_rd_a     = '0;
    index_a      = '0;
    mul_ena      = 1'b0;
    mul_high     = 1'b0;
    mul_signed   = 1'b0;
    mul_a        = '0;
    mul_b        = '0;
    reg_rd_mu    = '0;
    index_mu     = '0;
  endtask

  // Fresh operands and tags with enables left alone
  task automatic randomize_fields();
    branch_func = funcs[$urandom_range(5)];
    prediction  = 1'($urandom);
    pc          = $urandom;
    port_a      = $urandom;
    port_b      = $urandom;
    immediate   = $urandom;
    reg_rd_a    = exec_pkg::reg_addr_t'($urandom);
    index_a     = IDX_W'($urandom);
    mul_high    = 1'($urandom);
    mul_signed  = 1'($urandom);
    mul_a       = $urandom;
    mul_b       = $urandom;
    reg_rd_mu   = exec_pkg::reg_addr_t'($urandom);
    index_mu    = IDX_W'($urandom);
  endtask

  // Run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    logic [4:0] sel;
    void'($urandom(SEED));
    nRST = 1'b0;
    drive_idle();
    repeat (RESET_CYCLES) @(posedge CLK);
    #2;
    nRST = 1'b1;

    // Back-to-back corner multiplies beside branches on corner operands
    for (int i = 0; i < DIRECTED; i++) begin
      next_cycle();
      randomize_fields();
      sel          = 5'(i);
      alu_ena      = 1'b1;
      branch_instr = 1'b1;
      jump_instr   = 1'b0;
      branch_func  = funcs[i % 6];
      port_a       = corners[sel[1:0]];
      port_b       = corners[sel[3:2]];
      prediction   = sel[4];
      mul_ena      = 1'b1;
      mul_a        = corners[sel[1:0]];
      mul_b        = corners[sel[3:2]];
      mul_signed   = sel[4];
      mul_high     = sel[4] ^ sel[0];
      flush        = 1'b0;
    end

    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      next_cycle();
      randomize_fields();
      alu_ena = 1'($urandom);
      if (alu_ena) begin
        jump_instr   = ($urandom_range(3) == 0);
        branch_instr = !jump_instr;
      end else begin
        jump_instr   = 1'b0;
        branch_instr = 1'b0;
      end
      if ($urandom_range(7) == 0) begin
        port_b = port_a;
      end
      mul_ena = 1'($urandom);
      flush   = ($urandom_range(15) == 0);
    end

    next_cycle();
    drive_idle();
    repeat (MUL_STAGES + 2) @(posedge CLK);
    @(negedge CLK);
    #1;
    assert_fails = uut.u_completion_latch.u_props.fail_count;
    $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
             check_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
exec_pkg.sv
branch_resolve.sv
mul_pipeline.sv
completion_latch.sv
ooo_execute_stage.sv
exec_properties.sv
tb_checker.sv
tb_ooo_execute_stage.sv

/* run.sh */
#!/bin/sh
# Build the execute stage testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --top-module tb_ooo_execute_stage \
  -f tb.f -o sim_tb &&
./obj_dir/sim_tb +verilator+error+limit+100 2>&1 | tee sim.log

# The log decides the result
grep -q "Simulation PASSED" sim.log && echo "run.sh: pass" || {
  echo "run.sh: fail"
  exit 1
}
